//--- src.f
hsdAcqPkg.sv
triggerConditioner.sv
rangeMonitor.sv
triggerSnapshot.sv
hsdRangeTop.sv
hsdRangeTop_checker.sv
tbHsdRangeTop.sv

//--- tbHsdRangeTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbHsdRangeTop;

    localparam int ADC_WIDTH = 12;
    localparam int CHANNEL_COUNT = 4;
    localparam int SAMPLES_PER_CLOCK = 2;
    localparam int BEAT_SAMPLES = CHANNEL_COUNT * SAMPLES_PER_CLOCK;
    localparam int SNAPSHOT_TIMEOUT = 20;

    typedef hsdAcqPkg::axiSample_t [BEAT_SAMPLES-1:0] beatData_t;

    logic sysClk;
    logic rstN;
    logic softTriggerStrobe;
    hsdAcqPkg::eventTriggers_t eventTriggers;
    hsdAcqPkg::triggerBus_t triggerEnable;
    logic rangeClearStrobe;
    logic sampleValid;
    beatData_t sampleData;
    logic snapshotValid;
    hsdAcqPkg::snapshotInfo_t snapshotInfo;
    hsdAcqPkg::channelRange_t [CHANNEL_COUNT-1:0] snapshotRanges;
    hsdAcqPkg::triggerCount_t triggerCount;

    // Reference model state
    hsdAcqPkg::channelRange_t expRange [CHANNEL_COUNT];
    hsdAcqPkg::triggerCount_t expCount;
    integer seed;

    hsdRangeTop #(
        .ADC_WIDTH         (ADC_WIDTH),
        .CHANNEL_COUNT     (CHANNEL_COUNT),
        .SAMPLES_PER_CLOCK (SAMPLES_PER_CLOCK)
    ) u_dut (
        .sysClk            (sysClk),
        .rstN              (rstN),
        .softTriggerStrobe (softTriggerStrobe),
        .eventTriggers     (eventTriggers),
        .triggerEnable     (triggerEnable),
        .rangeClearStrobe  (rangeClearStrobe),
        .sampleValid       (sampleValid),
        .sampleData        (sampleData),
        .snapshotValid     (snapshotValid),
        .snapshotInfo      (snapshotInfo),
        .snapshotRanges    (snapshotRanges),
        .triggerCount      (triggerCount)
    );

    always begin
        #20 sysClk = ~sysClk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting and compares

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Stop at the first assertion failure of the bound checker
    always @(negedge sysClk) begin
        if (u_dut.uChecker.failureCount != 0) begin
            failRun("an assertion in the bound checker failed");
        end
    end

    task automatic checkRange(input string name, input hsdAcqPkg::channelRange_t actual,
                              input hsdAcqPkg::channelRange_t expected);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic checkInfo(input string name, input hsdAcqPkg::snapshotInfo_t actual,
                             input hsdAcqPkg::snapshotInfo_t expected);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic checkCount(input string name, input hsdAcqPkg::triggerCount_t actual,
                              input hsdAcqPkg::triggerCount_t expected);
        if (actual !== expected) begin
            failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model

    // Arithmetic shift of the MSB-justified ADC value sign-extends it
    function automatic hsdAcqPkg::adcPeak_t signExtendAdc(input hsdAcqPkg::axiSample_t sample);
        logic signed [hsdAcqPkg::SAMPLE_CONTAINER_WIDTH-1:0] word;
        word = sample;
        return word >>> (hsdAcqPkg::SAMPLE_CONTAINER_WIDTH - ADC_WIDTH);
    endfunction

    task automatic clearModel();
        for (int ch = 0; ch < CHANNEL_COUNT; ch++) begin
            expRange[ch].minValue = 16'sh7fff;
            expRange[ch].maxValue = 16'sh8000;
        end
    endtask

    task automatic updateModel(input beatData_t data);
        hsdAcqPkg::adcPeak_t value;
        hsdAcqPkg::adcPeak_t curMin;
        hsdAcqPkg::adcPeak_t curMax;
        for (int ch = 0; ch < CHANNEL_COUNT; ch++) begin
            for (int s = 0; s < SAMPLES_PER_CLOCK; s++) begin
                value = signExtendAdc(data[ch*SAMPLES_PER_CLOCK + s]);
                curMin = expRange[ch].minValue;
                curMax = expRange[ch].maxValue;
                if (value < curMin) begin
                    expRange[ch].minValue = value;
                end
                if (value > curMax) begin
                    expRange[ch].maxValue = value;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and waits

    task automatic pulseSoftTrigger();
        softTriggerStrobe = 1'b1;
        @(negedge sysClk);
        softTriggerStrobe = 1'b0;
    endtask

    task automatic clearRanges();
        rangeClearStrobe = 1'b1;
        clearModel();
        @(negedge sysClk);
        rangeClearStrobe = 1'b0;
    endtask

    task automatic driveBeat(input beatData_t data);
        sampleValid = 1'b1;
        sampleData = data;
        updateModel(data);
        @(negedge sysClk);
    endtask

    task automatic driveRandomBeat();
        beatData_t data;
        for (int i = 0; i < BEAT_SAMPLES; i++) begin
            data[i] = hsdAcqPkg::axiSample_t'($random(seed));
        end
        driveBeat(data);
    endtask

    task automatic waitForSnapshot();
        int waited;
        logic seen;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < SNAPSHOT_TIMEOUT) begin
            @(negedge sysClk);
            waited++;
            seen = snapshotValid;
        end
        if (!seen) begin
            failRun("timeout: snapshotValid did not rise within 20 cycles");
        end
    endtask

    task automatic expectQuiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge sysClk);
            if (snapshotValid) begin
                failRun("snapshotValid rose although no trigger was expected");
            end
        end
    endtask

    // Waits for one snapshot and checks it fully against the model
    task automatic expectSnapshot(input hsdAcqPkg::triggerBus_t sources);
        hsdAcqPkg::snapshotInfo_t expInfo;
        waitForSnapshot();
        expCount = expCount + 1'b1;
        expInfo.sources = sources;
        expInfo.count = expCount;
        checkInfo("snapshotInfo", snapshotInfo, expInfo);
        checkCount("triggerCount", triggerCount, expCount);
        for (int ch = 0; ch < CHANNEL_COUNT; ch++) begin
            checkRange($sformatf("snapshotRanges[%0d]", ch), snapshotRanges[ch], expRange[ch]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic resetStateIsQuiet();
        expectQuiet(10);
        checkCount("triggerCount", triggerCount, '0);
        checkInfo("snapshotInfo", snapshotInfo, '0);
    endtask

    task automatic softTriggerFiresOnce();
        triggerEnable = 7'h01;
        pulseSoftTrigger();
        expectSnapshot(7'h01);
        expectQuiet(12);
        // Second strobe lands inside the stretch
        pulseSoftTrigger();
        @(negedge sysClk);
        pulseSoftTrigger();
        expectSnapshot(7'h01);
        expectQuiet(20);
        checkCount("triggerCount", triggerCount, expCount);
    endtask

    task automatic eventTriggersHonorMask();
        // Event line 2 is bus bit 3
        triggerEnable = 7'h08;
        eventTriggers = 6'b000100;
        expectSnapshot(7'h08);
        eventTriggers = '0;
        expectQuiet(6);
        // Line 4 (bit 5) is masked off
        eventTriggers = 6'b010000;
        expectQuiet(20);
        eventTriggers = '0;
        expectQuiet(6);
        triggerEnable = 7'h28;
        eventTriggers = 6'b010100;
        expectSnapshot(7'h28);
        eventTriggers = '0;
        expectQuiet(6);
        checkCount("triggerCount", triggerCount, expCount);
    endtask

    task automatic rangeTrackingMatchesModel();
        triggerEnable = 7'h01;
        clearRanges();
        repeat (30) driveRandomBeat();
        sampleValid = 1'b0;
        repeat (3) @(negedge sysClk);
        pulseSoftTrigger();
        expectSnapshot(7'h01);
        expectQuiet(12);
    endtask

    task automatic clearRestartsRanges();
        beatData_t known;
        triggerEnable = 7'h01;
        known = {16'h8000, 16'h7ff0, 16'hfff0, 16'h0010,
                 16'h4560, 16'hc350, 16'h0000, 16'h1ab0};
        clearRanges();
        driveBeat(known);
        sampleValid = 1'b0;
        repeat (3) @(negedge sysClk);
        pulseSoftTrigger();
        expectSnapshot(7'h01);
        expectQuiet(12);
        // No beat after this clear leaves the cleared bounds
        clearRanges();
        repeat (3) @(negedge sysClk);
        pulseSoftTrigger();
        expectSnapshot(7'h01);
        expectQuiet(12);
    endtask

    initial begin
        seed = 32'h1c422c10;
        sysClk = 1'b0;
        rstN = 1'b0;
        softTriggerStrobe = 1'b0;
        eventTriggers = '0;
        triggerEnable = '0;
        rangeClearStrobe = 1'b0;
        sampleValid = 1'b0;
        sampleData = '0;
        expCount = '0;
        clearModel();
        repeat (8) @(negedge sysClk);
        rstN = 1'b1;
        resetStateIsQuiet();
        softTriggerFiresOnce();
        eventTriggersHonorMask();
        rangeTrackingMatchesModel();
        clearRestartsRanges();
        if (u_dut.uChecker.failureCount == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            failRun("an assertion in the bound checker failed");
        end
    end

endmodule

`default_nettype wire

//--- hsdRangeTop_checker.sv
`timescale 1ns/1ps
`default_nettype none

module hsdRangeTop_checker (
    input  wire                       sysClk,
    input  wire                       rstN,
    input  wire                       snapshotValid,
    input  hsdAcqPkg::triggerBus_t    triggerStrobes,
    input  hsdAcqPkg::triggerCount_t  triggerCount
);

    // Number of failed assertions so far
    int failureCount = 0;

    //////////////////////////////////////////////////////////////////////
    // Pulse widths

    // One snapshot pulse per accepted trigger
    snapshotSingleCycle: assert property (
        @(posedge sysClk) disable iff (!rstN)
        snapshotValid |=> !snapshotValid
    ) else begin
        failureCount++;
        $error("snapshotValid high for two cycles in a row");
    end

    // Each strobe bit comes from one rising edge only
    strobeSingleCycle: assert property (
        @(posedge sysClk) disable iff (!rstN)
        (triggerStrobes & $past(triggerStrobes)) == '0
    ) else begin
        failureCount++;
        $error("triggerStrobes bit high for two cycles in a row");
    end

    //////////////////////////////////////////////////////////////////////
    // Trigger count

    // Count moves together with the snapshot pulse
    countStep: assert property (
        @(posedge sysClk) disable iff (!rstN)
        triggerCount == (snapshotValid ?
            hsdAcqPkg::triggerCount_t'($past(triggerCount) + 1) : $past(triggerCount))
    ) else begin
        failureCount++;
        $error("triggerCount did not step by one with snapshotValid");
    end

endmodule

bind hsdRangeTop hsdRangeTop_checker uChecker (
    .sysClk         (sysClk),
    .rstN           (rstN),
    .snapshotValid  (snapshotValid),
    .triggerStrobes (triggerStrobes),
    .triggerCount   (triggerCount)
);

`default_nettype wire

//--- hsdRangeTop.sv
`timescale 1ns/1ps
`default_nettype none

module hsdRangeTop #(
    parameter int ADC_WIDTH         = 12,
    parameter int CHANNEL_COUNT     = 4,
    parameter int SAMPLES_PER_CLOCK = 2
) (
    input  wire                                                       sysClk,
    input  wire                                                       rstN,

    // Trigger inputs
    input  wire                                                       softTriggerStrobe,
    input  hsdAcqPkg::eventTriggers_t                                 eventTriggers,
    input  hsdAcqPkg::triggerBus_t                                    triggerEnable,

    // Sample stream, no back-pressure
    input  wire                                                       rangeClearStrobe,
    input  wire                                                       sampleValid,
    input  hsdAcqPkg::axiSample_t [CHANNEL_COUNT*SAMPLES_PER_CLOCK-1:0] sampleData,

    // Snapshot results
    output logic                                                      snapshotValid,
    output hsdAcqPkg::snapshotInfo_t                                  snapshotInfo,
    output hsdAcqPkg::channelRange_t [CHANNEL_COUNT-1:0]              snapshotRanges,
    output hsdAcqPkg::triggerCount_t                                  triggerCount
);

    hsdAcqPkg::triggerBus_t triggerStrobes;
    hsdAcqPkg::channelRange_t [CHANNEL_COUNT-1:0] channelRanges;

    //////////////////////////////////////////////////////////////////////
    // Triggers

    triggerConditioner uTriggerConditioner (
        .sysClk            (sysClk),
        .rstN              (rstN),
        .softTriggerStrobe (softTriggerStrobe),
        .eventTriggers     (eventTriggers),
        .triggerStrobes    (triggerStrobes)
    );

    //////////////////////////////////////////////////////////////////////
    // ADC range tracking

    rangeMonitor #(
        .ADC_WIDTH         (ADC_WIDTH),
        .CHANNEL_COUNT     (CHANNEL_COUNT),
        .SAMPLES_PER_CLOCK (SAMPLES_PER_CLOCK)
    ) uRangeMonitor (
        .sysClk           (sysClk),
        .rstN             (rstN),
        .sampleValid      (sampleValid),
        .sampleData       (sampleData),
        .rangeClearStrobe (rangeClearStrobe),
        .channelRanges    (channelRanges)
    );

    //////////////////////////////////////////////////////////////////////
    // Snapshot on accepted trigger

    triggerSnapshot #(
        .CHANNEL_COUNT (CHANNEL_COUNT)
    ) uTriggerSnapshot (
        .sysClk         (sysClk),
        .rstN           (rstN),
        .triggerStrobes (triggerStrobes),
        .triggerEnable  (triggerEnable),
        .channelRanges  (channelRanges),
        .snapshotValid  (snapshotValid),
        .snapshotInfo   (snapshotInfo),
        .snapshotRanges (snapshotRanges),
        .triggerCount   (triggerCount)
    );

endmodule

`default_nettype wire

//--- triggerSnapshot.sv
`timescale 1ns/1ps
`default_nettype none

module triggerSnapshot #(
    parameter int CHANNEL_COUNT = 4
) (
    input  wire                                          sysClk,
    input  wire                                          rstN,
    input  hsdAcqPkg::triggerBus_t                       triggerStrobes,
    input  hsdAcqPkg::triggerBus_t                       triggerEnable,
    input  hsdAcqPkg::channelRange_t [CHANNEL_COUNT-1:0] channelRanges,
    output logic                                         snapshotValid,
    output hsdAcqPkg::snapshotInfo_t                     snapshotInfo,
    output hsdAcqPkg::channelRange_t [CHANNEL_COUNT-1:0] snapshotRanges,
    output hsdAcqPkg::triggerCount_t                     triggerCount
);

    hsdAcqPkg::triggerBus_t maskedStrobes;
    hsdAcqPkg::triggerCount_t nextCount;
    logic triggerAccepted;

    //////////////////////////////////////////////////////////////////////
    // Trigger qualification

    // Only enabled sources count
    assign maskedStrobes   = triggerStrobes & triggerEnable;
    assign triggerAccepted = |maskedStrobes;

    // Count including the trigger being accepted now
    assign nextCount = triggerCount + 1'b1;

    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            triggerCount <= '0;
        end else if (triggerAccepted) begin
            triggerCount <= nextCount;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Snapshot capture

    // Single-cycle valid pulse per accepted trigger
    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            snapshotValid <= 1'b0;
        end else begin
            snapshotValid <= triggerAccepted;
        end
    end

    // Held until the next accepted trigger
    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            snapshotInfo   <= '0;
            snapshotRanges <= '0;
        end else if (triggerAccepted) begin
            snapshotInfo.sources <= maskedStrobes;
            snapshotInfo.count   <= nextCount;
            snapshotRanges       <= channelRanges;
        end
    end

endmodule

`default_nettype wire

//--- rangeMonitor.sv
`timescale 1ns/1ps
`default_nettype none

module rangeMonitor #(
    parameter int ADC_WIDTH         = 12,
    parameter int CHANNEL_COUNT     = 4,
    parameter int SAMPLES_PER_CLOCK = 2
) (
    input  wire                                                       sysClk,
    input  wire                                                       rstN,
    input  wire                                                       sampleValid,
    input  hsdAcqPkg::axiSample_t [CHANNEL_COUNT*SAMPLES_PER_CLOCK-1:0] sampleData,
    input  wire                                                       rangeClearStrobe,
    output hsdAcqPkg::channelRange_t [CHANNEL_COUNT-1:0]              channelRanges
);

    //////////////////////////////////////////////////////////////////////
    // Cleared state

    // Most positive and most negative readings
    localparam hsdAcqPkg::adcPeak_t PEAK_MOST_POSITIVE = {1'b0, {hsdAcqPkg::PEAK_WIDTH-1{1'b1}}};
    localparam hsdAcqPkg::adcPeak_t PEAK_MOST_NEGATIVE = {1'b1, {hsdAcqPkg::PEAK_WIDTH-1{1'b0}}};

    // Any real reading replaces both bounds
    localparam hsdAcqPkg::channelRange_t RANGE_CLEARED = '{
        minValue: PEAK_MOST_POSITIVE,
        maxValue: PEAK_MOST_NEGATIVE
    };

    //////////////////////////////////////////////////////////////////////
    // Sample extraction

    // Upper ADC_WIDTH bits of the container, sign-extended
    function automatic hsdAcqPkg::adcPeak_t extendSample(
        input hsdAcqPkg::axiSample_t sample
    );
        logic signed [ADC_WIDTH-1:0] adcValue;
        adcValue = sample[hsdAcqPkg::SAMPLE_CONTAINER_WIDTH-1 -: ADC_WIDTH];
        return hsdAcqPkg::adcPeak_t'(adcValue);
    endfunction

    // Stage 1 valid flag, shared by all channels
    logic stageValid;

    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= sampleValid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Per-channel pipeline

    for (genvar ch = 0; ch < CHANNEL_COUNT; ch++) begin : channelGen

        hsdAcqPkg::adcPeak_t sampleValue [SAMPLES_PER_CLOCK];
        hsdAcqPkg::channelRange_t beatRange;
        hsdAcqPkg::channelRange_t stageRange;
        hsdAcqPkg::channelRange_t mergedRange;
        hsdAcqPkg::channelRange_t runningRange;

        // Channel ch owns containers ch*SAMPLES_PER_CLOCK and up
        for (genvar s = 0; s < SAMPLES_PER_CLOCK; s++) begin : sampleGen
            assign sampleValue[s] = extendSample(sampleData[ch*SAMPLES_PER_CLOCK + s]);
        end

        // Reduce one beat to its minimum and maximum
        always_comb begin
            beatRange.minValue = sampleValue[0];
            beatRange.maxValue = sampleValue[0];
            for (int s = 1; s < SAMPLES_PER_CLOCK; s++) begin
                if (sampleValue[s] < beatRange.minValue) begin
                    beatRange.minValue = sampleValue[s];
                end
                if (sampleValue[s] > beatRange.maxValue) begin
                    beatRange.maxValue = sampleValue[s];
                end
            end
        end

        // Stage 1 payload, only meaningful with stageValid
        always_ff @(posedge sysClk) begin
            if (sampleValid) begin
                stageRange <= beatRange;
            end
        end

        // Fold the stage 1 beat into the running range
        always_comb begin
            mergedRange = runningRange;
            if (stageRange.minValue < runningRange.minValue) begin
                mergedRange.minValue = stageRange.minValue;
            end
            if (stageRange.maxValue > runningRange.maxValue) begin
                mergedRange.maxValue = stageRange.maxValue;
            end
        end

        // Stage 2
        // A clear drops the beat already in stage 1 but not the incoming one
        always_ff @(posedge sysClk or negedge rstN) begin
            if (!rstN) begin
                runningRange <= RANGE_CLEARED;
            end else if (rangeClearStrobe) begin
                runningRange <= RANGE_CLEARED;
            end else if (stageValid) begin
                runningRange <= mergedRange;
            end
        end

        assign channelRanges[ch] = runningRange;

    end

endmodule

`default_nettype wire

//--- triggerConditioner.sv
`timescale 1ns/1ps
`default_nettype none

module triggerConditioner (
    input  wire                        sysClk,
    input  wire                        rstN,
    input  wire                        softTriggerStrobe,
    input  hsdAcqPkg::eventTriggers_t  eventTriggers,
    output hsdAcqPkg::triggerBus_t     triggerStrobes
);

    // Top bit of the counter is the soft level, high while count >= half
    localparam int STRETCH_WIDTH = $clog2(hsdAcqPkg::SOFT_STRETCH_CYCLES) + 1;
    localparam logic [STRETCH_WIDTH-1:0] STRETCH_LOAD =
        STRETCH_WIDTH'(2 * hsdAcqPkg::SOFT_STRETCH_CYCLES - 1);

    logic [STRETCH_WIDTH-1:0] stretchCount;
    logic softLevel;

    hsdAcqPkg::triggerBus_t levelBus;
    hsdAcqPkg::triggerBus_t syncMeta;
    hsdAcqPkg::triggerBus_t syncStage;
    hsdAcqPkg::triggerBus_t syncDelay;

    //////////////////////////////////////////////////////////////////////
    // Soft trigger stretcher

    assign softLevel = stretchCount[STRETCH_WIDTH-1];

    // A strobe during the stretch just reloads, so the level never drops
    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            stretchCount <= '0;
        end else if (softTriggerStrobe) begin
            stretchCount <= STRETCH_LOAD;
        end else if (softLevel) begin
            stretchCount <= stretchCount - 1'b1;
        end
    end

    // Event lines 5..0 above the soft level
    assign levelBus = {eventTriggers, softLevel};

    //////////////////////////////////////////////////////////////////////
    // Synchronizer and edge detect

    // Two flops for the asynchronous event inputs
    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            syncMeta  <= '0;
            syncStage <= '0;
        end else begin
            syncMeta  <= levelBus;
            syncStage <= syncMeta;
        end
    end

    // Delay flop and registered rising-edge strobes
    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            syncDelay      <= '0;
            triggerStrobes <= '0;
        end else begin
            syncDelay      <= syncStage;
            triggerStrobes <= syncStage & ~syncDelay;
        end
    end

endmodule

`default_nettype wire

//--- hsdAcqPkg.sv
`default_nettype none

package hsdAcqPkg;

    //////////////////////////////////////////////////////////////////////
    // Fixed widths

    // One stream sample container, ADC value MSB-justified
    localparam int SAMPLE_CONTAINER_WIDTH = 16;

    // External event trigger lines
    localparam int EVENT_TRIGGER_WIDTH = 6;

    // Event lines plus the soft trigger in bit 0
    localparam int TRIGGER_BUS_WIDTH = EVENT_TRIGGER_WIDTH + 1;

    // Length of the stretched soft trigger level
    localparam int SOFT_STRETCH_CYCLES = 8;

    // Sign-extended ADC reading and trigger count
    localparam int PEAK_WIDTH = 16;
    localparam int TRIGGER_COUNT_WIDTH = 16;

    //////////////////////////////////////////////////////////////////////
    // Vector types

    typedef logic [SAMPLE_CONTAINER_WIDTH-1:0] axiSample_t;
    typedef logic signed [PEAK_WIDTH-1:0] adcPeak_t;
    typedef logic [EVENT_TRIGGER_WIDTH-1:0] eventTriggers_t;

    // Used for trigger levels as well as strobes
    typedef logic [TRIGGER_BUS_WIDTH-1:0] triggerBus_t;

    // Wraps silently
    typedef logic [TRIGGER_COUNT_WIDTH-1:0] triggerCount_t;

    //////////////////////////////////////////////////////////////////////
    // Grouped signals

    // Tracked range of one channel
    typedef struct packed {
        adcPeak_t minValue;
        adcPeak_t maxValue;
    } channelRange_t;

    // Trigger information captured with each snapshot
    typedef struct packed {
        triggerBus_t sources;
        triggerCount_t count;
    } snapshotInfo_t;

endpackage

`default_nettype wire
